//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= list.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "No result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/lsu_dmem.sv
module lsu_dmem
#(
    parameter int DMEM_ADDR_BITS = 8
)
(
    input  logic                        clk,

    input  logic                        dcs,
    input  logic                        dwr,
    input  logic [lsu_pkg::DATA_W-1:0]  daddr,
    input  logic [lsu_pkg::MASK_W-1:0]  dmask,
    input  logic [lsu_pkg::DATA_W-1:0]  dout,

    output logic [lsu_pkg::DATA_W-1:0]  rdata
);

    import lsu_pkg::*;

    localparam int DEPTH = 1 << DMEM_ADDR_BITS;

    logic [DATA_W-1:0]          mem [DEPTH];
    logic [DMEM_ADDR_BITS-1:0]  widx;

    // Upper word index bits are dropped, so the memory aliases.
    assign widx = daddr[DMEM_ADDR_BITS+1:2];

    // Old word is read in the same access that writes, for exchange.
    always_ff @(posedge clk)
    begin
        if (dcs)
        begin
            rdata <= mem[widx];
            if (dwr)
            begin
                for (int b = 0; b < MASK_W; b++)
                begin
                    if (dmask[b])
                        mem[widx][b*8 +: 8] <= dout[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- hw/lsu_issue.sv
module lsu_issue
(
    input  logic                           clk,
    input  logic                           rst,

    input  logic [lsu_pkg::DATA_W-1:0]     regs [lsu_pkg::NUM_REGS],

    input  logic                           ls_dir_en,
    input  logic                           ls_dir_store,
    input  logic [lsu_pkg::REG_IDX_W-1:0]  ls_dir_reg,
    input  logic [lsu_pkg::DATA_W-1:0]     ls_dir_addr,

    input  logic                           ls_op_en,
    input  logic [lsu_pkg::OP_W-1:0]       ls_op,

    output logic                           dcs,
    output logic                           dwr,
    output logic [lsu_pkg::DATA_W-1:0]     daddr,
    output logic [lsu_pkg::MASK_W-1:0]     dmask,
    output logic [lsu_pkg::DATA_W-1:0]     dout,

    output logic                           rcn_cs,
    output logic                           rcn_xch,
    output logic                           rcn_wr,
    output logic [lsu_pkg::DATA_W-1:0]     rcn_addr,
    output logic [lsu_pkg::REG_IDX_W-1:0]  rcn_wbreg,
    output logic [lsu_pkg::MASK_W-1:0]     rcn_mask,
    output logic [lsu_pkg::DATA_W-1:0]     rcn_wdata,

    output logic                           ld_issue,
    output logic                           ptr_issue,
    output logic [lsu_pkg::REG_IDX_W-1:0]  issue_wbreg,
    output logic [lsu_pkg::REG_IDX_W-1:0]  issue_ptr_reg,
    output logic [lsu_pkg::DATA_W-1:0]     issue_ptr_next,
    output logic [lsu_pkg::MASK_W-1:0]     issue_mask
);

    import lsu_pkg::*;

    logic                  op_st;
    logic                  op_post_inc;
    ls_type_e              op_type;
    logic [OFF_W-1:0]      op_off;
    logic [REG_IDX_W-1:0]  op_ptr;
    logic [REG_IDX_W-1:0]  op_reg;

    ls_type_e              acc_type;
    logic                  wren;
    logic                  xchg;
    logic                  issue_en;
    logic [REG_IDX_W-1:0]  wbreg;

    logic [DATA_W-1:0]     ptr_aligned;
    logic [DATA_W-1:0]     off_ext;
    logic [DATA_W-1:0]     ptr_next;
    logic [DATA_W-1:0]     bus_addr;
    logic [DATA_W-1:0]     wsrc;
    logic [DATA_W-1:0]     wdata;
    logic [MASK_W-1:0]     wmask;
    logic                  data_bus_en;
    logic                  rcn_bus_en;

    assign op_st       = ls_op[14];
    assign op_post_inc = ls_op[13];
    assign op_type     = ls_type_e'(ls_op[12:11]);
    assign op_off      = ls_op[10:6];
    assign op_ptr      = ls_op[5:3];
    assign op_reg      = ls_op[2:0];

    // Direct operations always move whole words and never exchange.
    assign acc_type = ls_dir_en ? LS_WORD : op_type;
    assign wren     = ls_dir_en ? ls_dir_store : op_st;
    assign xchg     = !ls_dir_en && op_st && (op_type == LS_XCHG);
    assign wbreg    = ls_dir_en ? ls_dir_reg : op_reg;
    assign issue_en = ls_dir_en || ls_op_en;

    assign off_ext = {{(DATA_W - OFF_W){op_off[OFF_W-1]}}, op_off};

    // Align the pointer and scale the offset by the access size.
    always_comb
    begin
        case (op_type)
            LS_BYTE:
            begin
                ptr_aligned = regs[op_ptr];
                ptr_next    = ptr_aligned + off_ext;
            end
            LS_HALF:
            begin
                ptr_aligned = {regs[op_ptr][DATA_W-1:1], 1'b0};
                ptr_next    = ptr_aligned + (off_ext << 1);
            end
            default:
            begin
                ptr_aligned = {regs[op_ptr][DATA_W-1:2], 2'b00};
                ptr_next    = ptr_aligned + (off_ext << 2);
            end
        endcase
    end

    assign bus_addr = ls_dir_en ? ls_dir_addr : (op_post_inc ? ptr_aligned : ptr_next);

    assign wsrc = regs[wbreg];

    always_comb
    begin
        case (acc_type)
            LS_BYTE:
            begin
                wdata = {MASK_W{wsrc[7:0]}};
                wmask = MASK_W'(1) << bus_addr[1:0];
            end
            LS_HALF:
            begin
                wdata = {(MASK_W / 2){wsrc[15:0]}};
                wmask = bus_addr[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                wdata = wsrc;
                wmask = '1;
            end
        endcase
    end

    assign data_bus_en = issue_en && !bus_addr[RCN_ADDR_BIT];
    assign rcn_bus_en  = issue_en && bus_addr[RCN_ADDR_BIT];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dcs    <= 1'b0;
            rcn_cs <= 1'b0;
        end
        else
        begin
            dcs    <= data_bus_en;
            rcn_cs <= rcn_bus_en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (data_bus_en)
        begin
            dwr   <= wren;
            daddr <= bus_addr;
            dmask <= wmask;
            dout  <= wdata;
        end
        if (rcn_bus_en)
        begin
            rcn_xch   <= xchg;
            rcn_wr    <= wren;
            rcn_addr  <= bus_addr;
            rcn_wbreg <= wbreg;
            rcn_mask  <= wmask;
            rcn_wdata <= wdata;
        end
    end

    // Only data-bus reads come back through retire.
    assign ld_issue       = data_bus_en && (!wren || xchg);
    assign ptr_issue      = ls_op_en && !ls_dir_en && op_post_inc;
    assign issue_wbreg    = wbreg;
    assign issue_ptr_reg  = op_ptr;
    assign issue_ptr_next = ptr_next;
    assign issue_mask     = wmask;

endmodule

//--- hw/lsu_pkg.sv
package lsu_pkg;

    // Data path and lane geometry.
    localparam int DATA_W = 32;
    localparam int MASK_W = DATA_W / 8;

    // Register file geometry.
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS = 1 << REG_IDX_W;

    // Encoded operation word.
    localparam int OP_W = 15;
    localparam int OFF_W = 5;

    // Addresses with this bit set go out on the register bus.
    localparam int RCN_ADDR_BIT = 31;

    // Access type, taken from operation bits 12:11.
    typedef enum logic [1:0]
    {
        LS_BYTE = 2'd0,
        LS_HALF = 2'd1,
        LS_WORD = 2'd2,
        LS_XCHG = 2'd3
    } ls_type_e;

endpackage

//--- hw/lsu_regfile.sv
module lsu_regfile
(
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           reg_wr_en,
    input  logic [lsu_pkg::REG_IDX_W-1:0]  reg_wr_idx,
    input  logic [lsu_pkg::DATA_W-1:0]     reg_wr_data,

    input  logic                           wb_store_en,
    input  logic [lsu_pkg::REG_IDX_W-1:0]  wb_store_reg,
    input  logic [lsu_pkg::DATA_W-1:0]     wb_store_data,

    input  logic                           wb_ptr_en,
    input  logic [lsu_pkg::REG_IDX_W-1:0]  wb_ptr_reg,
    input  logic [lsu_pkg::DATA_W-1:0]     wb_ptr_data,

    input  logic [lsu_pkg::REG_IDX_W-1:0]  reg_rd_idx,
    output logic [lsu_pkg::DATA_W-1:0]     reg_rd_data,

    output logic [lsu_pkg::DATA_W-1:0]     regs [lsu_pkg::NUM_REGS]
);

    import lsu_pkg::*;

    // Host write wins over load writeback, which wins over pointer writeback.
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                if (reg_wr_en && (reg_wr_idx == REG_IDX_W'(i)))
                    regs[i] <= reg_wr_data;
                else if (wb_store_en && (wb_store_reg == REG_IDX_W'(i)))
                    regs[i] <= wb_store_data;
                else if (wb_ptr_en && (wb_ptr_reg == REG_IDX_W'(i)))
                    regs[i] <= wb_ptr_data;
            end
        end
    end

    assign reg_rd_data = regs[reg_rd_idx];

endmodule

//--- hw/lsu_retire.sv
module lsu_retire
(
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           ld_issue,
    input  logic                           ptr_issue,
    input  logic [lsu_pkg::REG_IDX_W-1:0]  issue_wbreg,
    input  logic [lsu_pkg::REG_IDX_W-1:0]  issue_ptr_reg,
    input  logic [lsu_pkg::DATA_W-1:0]     issue_ptr_next,
    input  logic [lsu_pkg::MASK_W-1:0]     issue_mask,

    input  logic [lsu_pkg::DATA_W-1:0]     rdata,

    output logic                           wb_store_en,
    output logic [lsu_pkg::REG_IDX_W-1:0]  wb_store_reg,
    output logic [lsu_pkg::DATA_W-1:0]     wb_store_data,

    output logic                           wb_ptr_en,
    output logic [lsu_pkg::REG_IDX_W-1:0]  wb_ptr_reg,
    output logic [lsu_pkg::DATA_W-1:0]     wb_ptr_data
);

    import lsu_pkg::*;

    logic [2:0]            ld_d;
    logic [2:0]            ptr_d;
    logic [REG_IDX_W-1:0]  wbreg_d [3];
    logic [REG_IDX_W-1:0]  ptr_reg_d [3];
    logic [DATA_W-1:0]     ptr_next_d [3];
    logic [MASK_W-1:0]     mask_d [3];
    logic [DATA_W-1:0]     data_in;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ld_d  <= '0;
            ptr_d <= '0;
        end
        else
        begin
            ld_d  <= {ld_d[1:0], ld_issue};
            ptr_d <= {ptr_d[1:0], ptr_issue};
        end
    end

    always_ff @(posedge clk)
    begin
        wbreg_d    <= '{issue_wbreg, wbreg_d[0], wbreg_d[1]};
        ptr_reg_d  <= '{issue_ptr_reg, ptr_reg_d[0], ptr_reg_d[1]};
        ptr_next_d <= '{issue_ptr_next, ptr_next_d[0], ptr_next_d[1]};
        mask_d     <= '{issue_mask, mask_d[0], mask_d[1]};
        // Memory data arrives one cycle after the request.
        data_in    <= rdata;
    end

    // The lane mask picks the part of the word that was read.
    always_comb
    begin
        case (mask_d[2])
            4'b0011: wb_store_data = {16'd0, data_in[15:0]};
            4'b1100: wb_store_data = {16'd0, data_in[31:16]};
            4'b0001: wb_store_data = {24'd0, data_in[7:0]};
            4'b0010: wb_store_data = {24'd0, data_in[15:8]};
            4'b0100: wb_store_data = {24'd0, data_in[23:16]};
            4'b1000: wb_store_data = {24'd0, data_in[31:24]};
            default: wb_store_data = data_in;
        endcase
    end

    assign wb_store_en  = ld_d[2];
    assign wb_store_reg = wbreg_d[2];

    assign wb_ptr_en   = ptr_d[2];
    assign wb_ptr_reg  = ptr_reg_d[2];
    assign wb_ptr_data = ptr_next_d[2];

endmodule

//--- hw/lsu_top.sv
module lsu_top
#(
    parameter int DMEM_ADDR_BITS = 8
)
(
    input  logic                           clk,
    input  logic                           rst,

    input  logic                           reg_wr_en,
    input  logic [lsu_pkg::REG_IDX_W-1:0]  reg_wr_idx,
    input  logic [lsu_pkg::DATA_W-1:0]     reg_wr_data,

    input  logic                           ls_dir_en,
    input  logic                           ls_dir_store,
    input  logic [lsu_pkg::REG_IDX_W-1:0]  ls_dir_reg,
    input  logic [lsu_pkg::DATA_W-1:0]     ls_dir_addr,

    input  logic                           ls_op_en,
    input  logic [lsu_pkg::OP_W-1:0]       ls_op,

    input  logic [lsu_pkg::REG_IDX_W-1:0]  reg_rd_idx,
    output logic [lsu_pkg::DATA_W-1:0]     reg_rd_data,

    output logic                           rcn_cs,
    output logic                           rcn_xch,
    output logic                           rcn_wr,
    output logic [lsu_pkg::DATA_W-1:0]     rcn_addr,
    output logic [lsu_pkg::REG_IDX_W-1:0]  rcn_wbreg,
    output logic [lsu_pkg::MASK_W-1:0]     rcn_mask,
    output logic [lsu_pkg::DATA_W-1:0]     rcn_wdata
);

    import lsu_pkg::*;

    logic [DATA_W-1:0]     regs [NUM_REGS];

    logic                  dcs;
    logic                  dwr;
    logic [DATA_W-1:0]     daddr;
    logic [MASK_W-1:0]     dmask;
    logic [DATA_W-1:0]     dout;
    logic [DATA_W-1:0]     rdata;

    logic                  ld_issue;
    logic                  ptr_issue;
    logic [REG_IDX_W-1:0]  issue_wbreg;
    logic [REG_IDX_W-1:0]  issue_ptr_reg;
    logic [DATA_W-1:0]     issue_ptr_next;
    logic [MASK_W-1:0]     issue_mask;

    logic                  wb_store_en;
    logic [REG_IDX_W-1:0]  wb_store_reg;
    logic [DATA_W-1:0]     wb_store_data;
    logic                  wb_ptr_en;
    logic [REG_IDX_W-1:0]  wb_ptr_reg;
    logic [DATA_W-1:0]     wb_ptr_data;

    lsu_regfile u_regfile (.*);

    lsu_issue u_issue (.*);

    lsu_retire u_retire (.*);

    lsu_dmem #(.DMEM_ADDR_BITS(DMEM_ADDR_BITS)) u_dmem (.*);

endmodule

//--- list.f
hw/lsu_pkg.sv
hw/lsu_regfile.sv
hw/lsu_issue.sv
hw/lsu_retire.sv
hw/lsu_dmem.sv
hw/lsu_top.sv
verif/lsu_asserts.sv
verif/lsu_tb.sv

//--- verif/lsu_asserts.sv
module lsu_asserts
(
    input logic                        clk,
    input logic                        rst,
    input logic                        dcs,
    input logic                        rcn_cs,
    input logic [lsu_pkg::DATA_W-1:0]  rcn_addr,
    input logic                        ld_issue,
    input logic                        wb_store_en
);

    timeunit 1ns;
    timeprecision 100ps;

    import lsu_pkg::*;

    int unsigned fail_count = 0;

    bus_exclusive: assert property (@(posedge clk) disable iff (rst) !(dcs && rcn_cs))
    else
    begin
        $error("dcs and rcn_cs high in the same cycle");
        fail_count++;
    end

    rcn_high_addr: assert property (@(posedge clk) disable iff (rst)
        rcn_cs |-> rcn_addr[RCN_ADDR_BIT])
    else
    begin
        $error("rcn_cs raised for an address with bit 31 clear");
        fail_count++;
    end

    // Writeback comes two cycles after the memory request.
    load_latency: assert property (@(posedge clk) disable iff (rst)
        ld_issue |=> dcs ##2 wb_store_en)
    else
    begin
        $error("load writeback did not follow dcs by two cycles");
        fail_count++;
    end

endmodule

bind lsu_top lsu_asserts u_asserts
(
    .clk(clk),
    .rst(rst),
    .dcs(dcs),
    .rcn_cs(rcn_cs),
    .rcn_addr(rcn_addr),
    .ld_issue(ld_issue),
    .wb_store_en(wb_store_en)
);

//--- verif/lsu_tb.sv
module lsu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import lsu_pkg::*;

    localparam int DMEM_ADDR_BITS = 8;
    localparam int NUM_TESTS = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic                  clk;
    logic                  rst;
    logic                  reg_wr_en;
    logic [REG_IDX_W-1:0]  reg_wr_idx;
    logic [DATA_W-1:0]     reg_wr_data;
    logic                  ls_dir_en;
    logic                  ls_dir_store;
    logic [REG_IDX_W-1:0]  ls_dir_reg;
    logic [DATA_W-1:0]     ls_dir_addr;
    logic                  ls_op_en;
    logic [OP_W-1:0]       ls_op;
    logic [REG_IDX_W-1:0]  reg_rd_idx;
    logic [DATA_W-1:0]     reg_rd_data;
    logic                  rcn_cs;
    logic                  rcn_xch;
    logic                  rcn_wr;
    logic [DATA_W-1:0]     rcn_addr;
    logic [REG_IDX_W-1:0]  rcn_wbreg;
    logic [MASK_W-1:0]     rcn_mask;
    logic [DATA_W-1:0]     rcn_wdata;

    // Reference model of the register file and the aliased data memory.
    logic [DATA_W-1:0]     reg_model [NUM_REGS];
    logic [DATA_W-1:0]     mem_model [1 << DMEM_ADDR_BITS];
    logic [DATA_W-1:0]     last_addr;
    int                    errors;
    int                    assert_fails;
    integer                seed;

    lsu_top #(.DMEM_ADDR_BITS(DMEM_ADDR_BITS)) u_lsu_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic int unsigned access_size(ls_type_e t);
        case (t)
            LS_BYTE: return 1;
            LS_HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // Lowest byte lane touched, with the address aligned to the access size.
    function automatic int unsigned first_lane(ls_type_e t, logic [DATA_W-1:0] addr);
        return (32'(addr[1:0]) / access_size(t)) * access_size(t);
    endfunction

    function automatic logic [MASK_W-1:0] lane_mask(ls_type_e t, logic [DATA_W-1:0] addr);
        logic [MASK_W-1:0] m;
        m = '0;
        for (int unsigned k = 0; k < access_size(t); k++)
            m[first_lane(t, addr) + k] = 1'b1;
        return m;
    endfunction

    function automatic logic [DATA_W-1:0] replicate(ls_type_e t, logic [DATA_W-1:0] src);
        logic [DATA_W-1:0] w;
        for (int unsigned b = 0; b < MASK_W; b++)
            w[b*8 +: 8] = src[(b % access_size(t)) * 8 +: 8];
        return w;
    endfunction

    function automatic logic [DATA_W-1:0] aligned_ptr(ls_type_e t, logic [DATA_W-1:0] ptr);
        return ptr & ~(DATA_W'(access_size(t)) - 32'd1);
    endfunction

    function automatic logic [DATA_W-1:0] offset_ptr(ls_type_e t, logic [DATA_W-1:0] ptr,
                                                     int off);
        return aligned_ptr(t, ptr) + DATA_W'(off * int'(access_size(t)));
    endfunction

    // Applies one access to the model; an exchange stores and loads the same word.
    task automatic model_apply(input logic store, input ls_type_e t,
                               input logic [DATA_W-1:0] addr, input int dreg);
        logic [DMEM_ADDR_BITS-1:0] widx;
        logic [DATA_W-1:0]         old_word;
        logic [DATA_W-1:0]         src;
        logic [DATA_W-1:0]         loaded;
        widx = addr[DMEM_ADDR_BITS+1:2];
        old_word = mem_model[widx];
        src = reg_model[dreg];
        loaded = '0;
        for (int unsigned k = 0; k < access_size(t); k++)
            loaded[k*8 +: 8] = old_word[(first_lane(t, addr) + k) * 8 +: 8];
        if (!addr[RCN_ADDR_BIT])
        begin
            if (store)
            begin
                for (int unsigned k = 0; k < access_size(t); k++)
                    mem_model[widx][(first_lane(t, addr) + k) * 8 +: 8] = src[k*8 +: 8];
            end
            if (!store || t == LS_XCHG)
                reg_model[dreg] = loaded;
        end
    endtask

    task automatic preload(input int idx, input logic [DATA_W-1:0] value);
        reg_wr_en   <= 1'b1;
        reg_wr_idx  <= REG_IDX_W'(idx);
        reg_wr_data <= value;
        @(posedge clk);
        reg_wr_en <= 1'b0;
        reg_model[idx] = value;
    endtask

    task automatic issue_op(input logic store, input logic post_inc, input ls_type_e t,
                            input int off, input int ptr, input int dreg);
        logic [DATA_W-1:0] base;
        logic [DATA_W-1:0] next;
        logic              loads;
        base = reg_model[ptr];
        next = offset_ptr(t, base, off);
        last_addr = post_inc ? aligned_ptr(t, base) : next;
        loads = !last_addr[RCN_ADDR_BIT] && (!store || t == LS_XCHG);
        ls_op_en <= 1'b1;
        ls_op    <= {store, post_inc, t, 5'(off), 3'(ptr), 3'(dreg)};
        @(posedge clk);
        ls_op_en <= 1'b0;
        model_apply(store, t, last_addr, dreg);
        // A load into the pointer register wins over the pointer update.
        if (post_inc && !(loads && dreg == ptr))
            reg_model[ptr] = next;
    endtask

    task automatic direct_access(input logic store, input int dreg,
                                 input logic [DATA_W-1:0] addr);
        ls_dir_en    <= 1'b1;
        ls_dir_store <= store;
        ls_dir_reg   <= REG_IDX_W'(dreg);
        ls_dir_addr  <= addr;
        @(posedge clk);
        ls_dir_en <= 1'b0;
        model_apply(store, LS_WORD, addr, dreg);
    endtask

    task automatic read_reg(input int idx, output logic [DATA_W-1:0] value);
        reg_rd_idx <= REG_IDX_W'(idx);
        repeat (4) @(posedge clk);
        @(negedge clk);
        value = reg_rd_data;
        @(posedge clk);
    endtask

    task automatic check_reg(input string name, input int idx);
        logic [DATA_W-1:0] value;
        read_reg(idx, value);
        check_value(name, reg_model[idx], value);
    endtask

    task automatic word_store_load();
        logic [DATA_W-1:0] addr;
        @(negedge clk);
        check_value("reset strobes", 32'd0, DATA_W'({u_lsu_top.dcs, rcn_cs,
                    u_lsu_top.wb_store_en, u_lsu_top.wb_ptr_en}));
        @(posedge clk);
        for (int i = 0; i < 4; i++)
        begin
            addr = $random(seed) & 32'h0000_0ffc;
            preload(1, $random(seed));
            direct_access(1'b1, 1, addr);
            direct_access(1'b0, 2, addr);
            check_reg("word store/load", 2);
        end
    endtask

    task automatic lane_access();
        preload(1, $random(seed));
        direct_access(1'b1, 1, 32'h0000_0100);
        for (int lane = 0; lane < 4; lane++)
        begin
            preload(3, $random(seed));
            preload(4, 32'h0000_0100 + 32'(lane));
            issue_op(1'b1, 1'b0, LS_BYTE, 0, 4, 3);
            direct_access(1'b0, 2, 32'h0000_0100);
            check_reg("byte store", 2);
            issue_op(1'b0, 1'b0, LS_BYTE, 0, 4, 5);
            check_reg("byte load", 5);
        end
        // Odd pointers check that halfword accesses align down.
        for (int half = 0; half < 2; half++)
        begin
            preload(3, $random(seed));
            preload(4, 32'h0000_0101 + 32'(2 * half));
            issue_op(1'b1, 1'b0, LS_HALF, 0, 4, 3);
            direct_access(1'b0, 2, 32'h0000_0100);
            check_reg("halfword store", 2);
            issue_op(1'b0, 1'b0, LS_HALF, 0, 4, 5);
            check_reg("halfword load", 5);
        end
    endtask

    task automatic pointer_offsets();
        ls_type_e          t;
        int                off;
        logic              post_inc;
        logic [DATA_W-1:0] ptr;
        logic [DATA_W-1:0] target;
        for (int i = 0; i < 8; i++)
        begin
            t = ls_type_e'(i % 3);
            off = int'($random(seed) % 16);
            post_inc = (i >= 4);
            ptr = 32'h0000_0400 | (32'($random(seed)) & 32'h0000_01ff);
            target = post_inc ? aligned_ptr(t, ptr) : offset_ptr(t, ptr, off);
            preload(1, $random(seed));
            direct_access(1'b1, 1, target);
            preload(3, $random(seed));
            preload(4, ptr);
            issue_op(1'b1, post_inc, t, off, 4, 3);
            check_reg("pointer register", 4);
            direct_access(1'b0, 2, target);
            check_reg("offset store target", 2);
        end
    endtask

    task automatic exchange_access();
        for (int i = 0; i < 2; i++)
        begin
            preload(1, $random(seed));
            direct_access(1'b1, 1, 32'h0000_0300);
            preload(3, $random(seed));
            preload(4, (i == 0) ? 32'h0000_0310 : 32'h0000_0302);
            issue_op(1'b1, i == 1, LS_XCHG, (i == 0) ? -4 : 1, 4, 3);
            check_reg("exchange load", 3);
            check_reg("exchange pointer", 4);
            direct_access(1'b0, 2, 32'h0000_0300);
            check_reg("exchange store", 2);
        end
    endtask

    task automatic register_bus_requests();
        ls_type_e          t;
        logic              store;
        logic [DATA_W-1:0] ptr;
        logic [DATA_W-1:0] low_addr;
        for (int i = 0; i < 4; i++)
        begin
            t = ls_type_e'(i);
            store = (i % 2) == 1;
            ptr = 32'h8000_0500 + 32'(i);
            low_addr = offset_ptr(t, ptr, 1) & 32'h7fff_ffff;
            preload(1, $random(seed));
            direct_access(1'b1, 1, low_addr);
            preload(3, $random(seed));
            preload(4, ptr);
            issue_op(store, 1'b0, t, 1, 4, 3);
            @(negedge clk);
            check_value("rcn_cs", 32'd1, DATA_W'(rcn_cs));
            check_value("dcs during rcn", 32'd0, DATA_W'(u_lsu_top.dcs));
            check_value("rcn_addr", last_addr, rcn_addr);
            check_value("rcn_mask", DATA_W'(lane_mask(t, last_addr)), DATA_W'(rcn_mask));
            check_value("rcn_wdata", replicate(t, reg_model[3]), rcn_wdata);
            check_value("rcn_wr", DATA_W'(store), DATA_W'(rcn_wr));
            check_value("rcn_xch", DATA_W'(store && t == LS_XCHG), DATA_W'(rcn_xch));
            check_value("rcn_wbreg", 32'd3, DATA_W'(rcn_wbreg));
            @(posedge clk);
            check_reg("rcn leaves register", 3);
            direct_access(1'b0, 2, low_addr);
            check_reg("rcn leaves memory", 2);
        end
    endtask

    // Two stores and two loads on consecutive cycles keep three in flight.
    task automatic back_to_back_ops();
        preload(1, $random(seed));
        preload(3, $random(seed));
        preload(4, 32'h0000_0602);
        direct_access(1'b1, 1, 32'h0000_0600);
        issue_op(1'b1, 1'b0, LS_BYTE, 1, 4, 3);
        direct_access(1'b0, 2, 32'h0000_0600);
        issue_op(1'b0, 1'b0, LS_HALF, 0, 4, 5);
        check_reg("back-to-back word", 2);
        check_reg("back-to-back half", 5);
    endtask

    initial
    begin
        seed = 32'hcc8edc6c;
        errors = 0;
        rst = 1'b1;
        reg_wr_en = 1'b0;
        reg_wr_idx = '0;
        reg_wr_data = '0;
        ls_dir_en = 1'b0;
        ls_dir_store = 1'b0;
        ls_dir_reg = '0;
        ls_dir_addr = '0;
        ls_op_en = 1'b0;
        ls_op = '0;
        reg_rd_idx = '0;
        for (int i = 0; i < NUM_REGS; i++)
            reg_model[i] = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        word_store_load();
        lane_access();
        pointer_offsets();
        exchange_access();
        register_bus_requests();
        back_to_back_ops();
        assert_fails = int'(u_lsu_top.u_asserts.fail_count);
        $display("Summary: %0d check errors, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
